/* source/invadersPkg.sv */
package invadersPkg;

    // reduced raster, 64x48 visible inside an 80x52 frame
    localparam int hActive = 64;
    localparam int vActive = 48;
    localparam int hTotal = 80;
    localparam int vTotal = 52;
    localparam int hSyncStart = 68;
    localparam int hSyncEnd = 76;
    localparam int vSyncStart = 49;
    localparam int vSyncEnd = 51;
    localparam int endZoneTop = vActive - 5;    // first of four rows above bottom border

    typedef logic [10:0] pixelT;
    typedef logic [7:0] rgbT;                   // rrr_ggg_bb

    localparam int numObjects = 9;
    localparam int objPlayer = 0;               // highest priority
    localparam int objPlayerMissile = 1;
    localparam int objMonster = 2;
    localparam int objMonsterMissile = 3;
    localparam int objAsteroid = 4;
    localparam int objBoss = 5;
    localparam int objBossMissile = 6;
    localparam int objLives = 7;
    localparam int objScore = 8;

    localparam int numCollisions = 7;
    typedef logic [numCollisions-1:0] collisionT;
    localparam int colMonsterShot = 0;
    localparam int colPlayerHit = 1;
    localparam int colAsteroidShot = 2;
    localparam int colBossShotPlayer = 3;
    localparam int colBossShot = 4;
    localparam int colMonsterLanded = 5;
    localparam int colMissileBorder = 6;

    localparam rgbT borderRgb = 8'hFF;          // white
    localparam rgbT endZoneRgb = 8'h1C;         // green
    localparam rgbT backgroundRgb = 8'h02;      // dark blue

    typedef logic [2:0] stageT;
    localparam stageT lastStage = 3'd3;         // boss stage

    typedef logic [3:0] scoreDigitT;
    typedef logic [6:0] segT;                   // gfedcba, active low
    localparam scoreDigitT monsterPoints = 4'd1;
    localparam scoreDigitT bossPoints = 4'd5;

    typedef enum logic [2:0] {sIdle, sStageLoad, sPlay, sPause, sWon, sOver} gameStateT;

endpackage

/* source/rasterScanner.sv */
`timescale 1ns/1ps

module rasterScanner (
    input  logic               clk,
    input  logic               rstN,
    output invadersPkg::pixelT pixelX,
    output invadersPkg::pixelT pixelY,
    output logic               startOfFrame,
    output logic               hSync,
    output logic               vSync,
    output logic               border,
    output logic               endZone
);

    invadersPkg::pixelT nextX;
    invadersPkg::pixelT nextY;
    logic lineEnd;
    logic nextVisible;

    assign lineEnd = (pixelX == invadersPkg::pixelT'(invadersPkg::hTotal - 1));
    assign nextX = lineEnd ? '0 : pixelX + 1'b1;

    always_comb begin
        nextY = pixelY;
        if (lineEnd) begin
            nextY = (pixelY == invadersPkg::pixelT'(invadersPkg::vTotal - 1)) ? '0 : pixelY + 1'b1;
        end
    end

    assign nextVisible = (nextX < invadersPkg::hActive) && (nextY < invadersPkg::vActive);

    // flags are computed from the next position so they line up with the counters
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pixelX <= '0;
            pixelY <= '0;
            startOfFrame <= 1'b1;     // counters restart at 0,0
            hSync <= 1'b1;
            vSync <= 1'b1;
            border <= 1'b1;           // 0,0 is a corner of the ring
            endZone <= 1'b0;
        end else begin
            pixelX <= nextX;
            pixelY <= nextY;
            startOfFrame <= (nextX == '0) && (nextY == '0);
            hSync <= !((nextX >= invadersPkg::hSyncStart) && (nextX < invadersPkg::hSyncEnd));
            vSync <= !((nextY >= invadersPkg::vSyncStart) && (nextY < invadersPkg::vSyncEnd));
            border <= nextVisible && ((nextX == '0) || (nextY == '0)
                      || (nextX == invadersPkg::pixelT'(invadersPkg::hActive - 1))
                      || (nextY == invadersPkg::pixelT'(invadersPkg::vActive - 1)));
            endZone <= nextVisible && (nextY >= invadersPkg::endZoneTop)
                       && (nextY < invadersPkg::vActive - 1);
        end
    end

endmodule

/* source/objectMixer.sv */
`timescale 1ns/1ps

module objectMixer (
    input  logic                                               clk,
    input  logic                                               rstN,
    input  logic [invadersPkg::numObjects-1:0]                 drawRequests,
    input  invadersPkg::rgbT [invadersPkg::numObjects-1:0]     objRgb,
    input  logic                                               border,
    input  logic                                               endZone,
    input  invadersPkg::pixelT                                 pixelX,
    input  invadersPkg::pixelT                                 pixelY,
    input  logic                                               hSync,
    input  logic                                               vSync,
    output invadersPkg::rgbT                                   vgaRgb,
    output logic                                               vgaHSync,
    output logic                                               vgaVSync
);

    invadersPkg::rgbT mixRgb;
    logic visible;

    assign visible = (pixelX < invadersPkg::hActive) && (pixelY < invadersPkg::vActive);

    always_comb begin
        mixRgb = invadersPkg::backgroundRgb;
        if (endZone) begin
            mixRgb = invadersPkg::endZoneRgb;
        end
        if (border) begin
            mixRgb = invadersPkg::borderRgb;
        end
        // walk from lowest to highest priority so the lowest index wins
        for (int i = invadersPkg::numObjects - 1; i >= 0; i--) begin
            if (drawRequests[i]) begin
                mixRgb = objRgb[i];
            end
        end
        if (!visible) begin
            mixRgb = '0;                // blanking
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            vgaRgb <= '0;
            vgaHSync <= 1'b1;
            vgaVSync <= 1'b1;
        end else begin
            vgaRgb <= mixRgb;
            vgaHSync <= hSync;          // same delay as the colour
            vgaVSync <= vSync;
        end
    end

endmodule

/* source/hitDetection.sv */
`timescale 1ns/1ps

module hitDetection (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               startOfFrame,
    input  logic [invadersPkg::numObjects-1:0] drawRequests,
    input  logic                               border,
    input  logic                               endZone,
    output invadersPkg::collisionT             collision
);

    invadersPkg::collisionT overlap;
    invadersPkg::collisionT seen;
    invadersPkg::collisionT newHit;
    logic anyMissile;

    assign anyMissile = drawRequests[invadersPkg::objPlayerMissile]
                        || drawRequests[invadersPkg::objMonsterMissile]
                        || drawRequests[invadersPkg::objBossMissile];

    always_comb begin
        overlap = '0;
        overlap[invadersPkg::colMonsterShot] =
            drawRequests[invadersPkg::objPlayerMissile] && drawRequests[invadersPkg::objMonster];
        overlap[invadersPkg::colPlayerHit] =
            drawRequests[invadersPkg::objMonsterMissile] && drawRequests[invadersPkg::objPlayer];
        overlap[invadersPkg::colAsteroidShot] =
            drawRequests[invadersPkg::objPlayerMissile] && drawRequests[invadersPkg::objAsteroid];
        overlap[invadersPkg::colBossShotPlayer] =
            drawRequests[invadersPkg::objBossMissile] && drawRequests[invadersPkg::objPlayer];
        overlap[invadersPkg::colBossShot] =
            drawRequests[invadersPkg::objPlayerMissile] && drawRequests[invadersPkg::objBoss];
        overlap[invadersPkg::colMonsterLanded] =
            drawRequests[invadersPkg::objMonster] && endZone;
        overlap[invadersPkg::colMissileBorder] = anyMissile && border;
    end

    // the frame start cycle itself counts as the first cycle of the new frame
    assign newHit = startOfFrame ? overlap : (overlap & ~seen);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            seen <= '0;
            collision <= '0;
        end else begin
            collision <= newHit;        // one cycle wide per pair and frame
            if (startOfFrame) begin
                seen <= overlap;
            end else begin
                seen <= seen | overlap;
            end
        end
    end

endmodule

/* source/gameController.sv */
`timescale 1ns/1ps

module gameController (
    input  logic               clk,
    input  logic               rstN,
    input  logic               startGame,
    input  logic               winStage,
    input  logic               playerDead,
    input  logic               skipStage,
    input  logic               pause,
    output logic               enablePlayer,
    output logic               enableMonsters,
    output logic               enableAsteroids,
    output logic               enableBoss,
    output logic               playerRstN,
    output logic               monstersRstN,
    output logic               asteroidsRstN,
    output logic               bossRstN,
    output invadersPkg::stageT stageNum,
    output logic               gameWon,
    output logic               gameOver
);

    invadersPkg::gameStateT state;
    invadersPkg::gameStateT nextState;
    invadersPkg::stageT nextStage;
    logic inPlay;
    logic stageLoad;

    always_comb begin
        nextState = state;
        nextStage = stageNum;
        case (state)
            invadersPkg::sIdle, invadersPkg::sWon, invadersPkg::sOver: begin
                if (startGame) begin
                    nextState = invadersPkg::sStageLoad;
                    nextStage = '0;
                end
            end
            invadersPkg::sStageLoad: nextState = invadersPkg::sPlay;
            invadersPkg::sPlay: begin
                if (playerDead) begin
                    nextState = invadersPkg::sOver;
                end else if (winStage || skipStage) begin
                    if (stageNum == invadersPkg::lastStage) begin
                        nextState = invadersPkg::sWon;
                    end else begin
                        nextState = invadersPkg::sStageLoad;
                        nextStage = stageNum + 1'b1;
                    end
                end else if (pause) begin
                    nextState = invadersPkg::sPause;
                end
            end
            invadersPkg::sPause: begin
                if (playerDead) begin
                    nextState = invadersPkg::sOver;
                end else if (!pause) begin
                    nextState = invadersPkg::sPlay;
                end
            end
            default: nextState = invadersPkg::sIdle;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= invadersPkg::sIdle;
            stageNum <= '0;
        end else begin
            state <= nextState;
            stageNum <= nextStage;
        end
    end

    assign inPlay = (state == invadersPkg::sPlay);
    assign stageLoad = (state == invadersPkg::sStageLoad);

    assign enablePlayer = inPlay;                                   // every stage
    assign enableMonsters = inPlay && (stageNum < 3'd2);            // stages 0 and 1
    assign enableAsteroids = inPlay && (stageNum == 3'd2);
    assign enableBoss = inPlay && (stageNum == invadersPkg::lastStage);

    // all groups restart together on a stage load
    assign playerRstN = !stageLoad;
    assign monstersRstN = !stageLoad;
    assign asteroidsRstN = !stageLoad;
    assign bossRstN = !stageLoad;

    assign gameWon = (state == invadersPkg::sWon);
    assign gameOver = (state == invadersPkg::sOver);

endmodule

/* source/scoreCounter.sv */
`timescale 1ns/1ps

module scoreCounter (
    input  logic                   clk,
    input  logic                   rstN,
    input  invadersPkg::collisionT collision,
    output invadersPkg::segT       hex0,
    output invadersPkg::segT       hex1,
    output invadersPkg::segT       hex2
);

    invadersPkg::scoreDigitT digit0, digit1, digit2;
    invadersPkg::scoreDigitT next0, next1, next2;
    invadersPkg::scoreDigitT addend;
    logic [4:0] sum0, sum1, sum2;
    logic carry0, carry1;

    function automatic invadersPkg::segT toSeg(input invadersPkg::scoreDigitT d);
        case (d)
            4'd0: toSeg = 7'b1000000;
            4'd1: toSeg = 7'b1111001;
            4'd2: toSeg = 7'b0100100;
            4'd3: toSeg = 7'b0110000;
            4'd4: toSeg = 7'b0011001;
            4'd5: toSeg = 7'b0010010;
            4'd6: toSeg = 7'b0000010;
            4'd7: toSeg = 7'b1111000;
            4'd8: toSeg = 7'b0000000;
            4'd9: toSeg = 7'b0010000;
            default: toSeg = 7'b1111111;    // dark
        endcase
    endfunction

    always_comb begin
        addend = '0;
        if (collision[invadersPkg::colMonsterShot]) begin
            addend = addend + invadersPkg::monsterPoints;
        end
        if (collision[invadersPkg::colBossShot]) begin
            addend = addend + invadersPkg::bossPoints;
        end
        sum0 = {1'b0, digit0} + {1'b0, addend};
        carry0 = (sum0 > 5'd9);
        next0 = carry0 ? sum0[3:0] - 4'd10 : sum0[3:0];
        sum1 = {1'b0, digit1} + {4'd0, carry0};
        carry1 = (sum1 > 5'd9);
        next1 = carry1 ? '0 : sum1[3:0];
        sum2 = {1'b0, digit2} + {4'd0, carry1};
        next2 = sum2[3:0];
        if (sum2 > 5'd9) begin
            next0 = 4'd9;                   // hold at 999
            next1 = 4'd9;
            next2 = 4'd9;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            digit0 <= '0;
            digit1 <= '0;
            digit2 <= '0;
        end else begin
            digit0 <= next0;
            digit1 <= next1;
            digit2 <= next2;
        end
    end

    assign hex0 = toSeg(digit0);
    assign hex1 = toSeg(digit1);
    assign hex2 = toSeg(digit2);

endmodule

/* source/invadersCore.sv */
`timescale 1ns/1ps

module invadersCore (
    input  logic                                           clk,
    input  logic                                           rstN,
    input  logic                                           startGame,
    input  logic                                           cheatN,
    input  logic                                           pause,
    input  logic                                           winStage,
    input  logic                                           playerDead,
    input  logic [invadersPkg::numObjects-1:0]             drawRequests,
    input  invadersPkg::rgbT [invadersPkg::numObjects-1:0] objRgb,
    output invadersPkg::pixelT                             pixelX,
    output invadersPkg::pixelT                             pixelY,
    output logic                                           startOfFrame,
    output invadersPkg::rgbT                               vgaRgb,
    output logic                                           vgaHSync,
    output logic                                           vgaVSync,
    output invadersPkg::collisionT                         collision,
    output logic                                           enablePlayer,
    output logic                                           enableMonsters,
    output logic                                           enableAsteroids,
    output logic                                           enableBoss,
    output logic                                           playerRstN,
    output logic                                           monstersRstN,
    output logic                                           asteroidsRstN,
    output logic                                           bossRstN,
    output invadersPkg::stageT                             stageNum,
    output logic                                           gameWon,
    output logic                                           gameOver,
    output invadersPkg::segT                               hex0,
    output invadersPkg::segT                               hex1,
    output invadersPkg::segT                               hex2
);

    logic hSync, vSync;
    logic border, endZone;
    logic skipStage;
    logic stagePlayerRstN, stageMonstersRstN, stageAsteroidsRstN, stageBossRstN;

    assign skipStage = ~cheatN;                 // cheat key is active low
    assign playerRstN = rstN & stagePlayerRstN;
    assign monstersRstN = rstN & stageMonstersRstN;
    assign asteroidsRstN = rstN & stageAsteroidsRstN;
    assign bossRstN = rstN & stageBossRstN;

    rasterScanner uRasterScanner (
        .clk(clk), .rstN(rstN), .pixelX(pixelX), .pixelY(pixelY),
        .startOfFrame(startOfFrame), .hSync(hSync), .vSync(vSync),
        .border(border), .endZone(endZone));

    objectMixer uObjectMixer (
        .clk(clk), .rstN(rstN), .drawRequests(drawRequests), .objRgb(objRgb),
        .border(border), .endZone(endZone), .pixelX(pixelX), .pixelY(pixelY),
        .hSync(hSync), .vSync(vSync), .vgaRgb(vgaRgb), .vgaHSync(vgaHSync),
        .vgaVSync(vgaVSync));

    hitDetection uHitDetection (
        .clk(clk), .rstN(rstN), .startOfFrame(startOfFrame), .drawRequests(drawRequests),
        .border(border), .endZone(endZone), .collision(collision));

    gameController uGameController (
        .clk(clk), .rstN(rstN), .startGame(startGame), .winStage(winStage),
        .playerDead(playerDead), .skipStage(skipStage), .pause(pause),
        .enablePlayer(enablePlayer), .enableMonsters(enableMonsters),
        .enableAsteroids(enableAsteroids), .enableBoss(enableBoss),
        .playerRstN(stagePlayerRstN), .monstersRstN(stageMonstersRstN),
        .asteroidsRstN(stageAsteroidsRstN), .bossRstN(stageBossRstN),
        .stageNum(stageNum), .gameWon(gameWon), .gameOver(gameOver));

    scoreCounter uScoreCounter (
        .clk(clk), .rstN(rstN), .collision(collision),
        .hex0(hex0), .hex1(hex1), .hex2(hex2));

endmodule

/* dv/invadersCoreTb.sv */
`timescale 1ns/1ps

module invadersCoreTb;

    logic clk = 1'b0;
    logic rstN, startGame, cheatN, pause, winStage, playerDead;
    logic [invadersPkg::numObjects-1:0] drawRequests;
    invadersPkg::rgbT [invadersPkg::numObjects-1:0] objRgb;
    invadersPkg::pixelT pixelX, pixelY;
    logic startOfFrame, vgaHSync, vgaVSync;
    logic hSyncExp, vSyncExp;
    invadersPkg::rgbT vgaRgb, rgbExp;
    invadersPkg::collisionT collision, colExp, seenRef, hitsNow;
    logic enablePlayer, enableMonsters, enableAsteroids, enableBoss;
    logic playerRstN, monstersRstN, asteroidsRstN, bossRstN;
    logic gameWon, gameOver;
    invadersPkg::stageT stageNum;
    invadersPkg::segT hex0, hex1, hex2;
    int refX, refY, scoreRef;
    logic frameStart;
    int frameErrors = 0;
    int mixErrors = 0;
    int syncErrors = 0;
    int hitErrors = 0;
    int scoreErrors = 0;
    int ctrlErrors = 0;

    invadersCore u_dut (.*);

    always #5 clk = ~clk;

    function automatic logic onBorder(input int x, input int y);
        return x < invadersPkg::hActive && y < invadersPkg::vActive
               && (x == 0 || y == 0 || x == invadersPkg::hActive - 1
                   || y == invadersPkg::vActive - 1);
    endfunction

    function automatic logic inEndZone(input int x, input int y);
        return x < invadersPkg::hActive && y >= invadersPkg::vActive - 5
               && y < invadersPkg::vActive - 1;      // four rows above the bottom ring
    endfunction

    function automatic invadersPkg::rgbT expectedRgb(input int x, input int y,
            input logic [8:0] req, input invadersPkg::rgbT [8:0] rgb);
        if (x >= invadersPkg::hActive || y >= invadersPkg::vActive) return '0;
        for (int i = 0; i < invadersPkg::numObjects; i++) begin
            if (req[i]) return rgb[i];               // lowest index wins
        end
        if (onBorder(x, y)) return invadersPkg::borderRgb;
        if (inEndZone(x, y)) return invadersPkg::endZoneRgb;
        return invadersPkg::backgroundRgb;
    endfunction

    function automatic invadersPkg::collisionT pairOverlap(input logic [8:0] req,
            input logic brd, input logic ez);
        invadersPkg::collisionT c;
        c[0] = req[1] && req[2];                     // player missile on monster
        c[1] = req[3] && req[0];
        c[2] = req[1] && req[4];
        c[3] = req[6] && req[0];
        c[4] = req[1] && req[5];
        c[5] = req[2] && ez;
        c[6] = (req[1] || req[3] || req[6]) && brd;  // any missile leaving the field
        return c;
    endfunction

    function automatic int addPoints(input int score, input invadersPkg::collisionT col);
        int sum;
        sum = score;
        if (col[invadersPkg::colMonsterShot]) sum += int'(invadersPkg::monsterPoints);
        if (col[invadersPkg::colBossShot]) sum += int'(invadersPkg::bossPoints);
        return (sum > 999) ? 999 : sum;
    endfunction

    function automatic invadersPkg::segT segOf(input int d);
        case (d)
            0: return 7'h40;
            1: return 7'h79;
            2: return 7'h24;
            3: return 7'h30;
            4: return 7'h19;
            5: return 7'h12;
            6: return 7'h02;
            7: return 7'h78;
            8: return 7'h00;
            default: return 7'h10;
        endcase
    endfunction

    assign frameStart = (refX == 0) && (refY == 0);
    assign hitsNow = pairOverlap(drawRequests, onBorder(refX, refY), inEndZone(refX, refY));

    // reference raster, colour, syncs, collision and score
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            refX <= 0;
            refY <= 0;
            rgbExp <= '0;
            hSyncExp <= 1'b1;
            vSyncExp <= 1'b1;
            colExp <= '0;
            seenRef <= '0;
            scoreRef <= 0;
        end else begin
            refX <= (refX == invadersPkg::hTotal - 1) ? 0 : refX + 1;
            if (refX == invadersPkg::hTotal - 1) begin
                refY <= (refY == invadersPkg::vTotal - 1) ? 0 : refY + 1;
            end
            rgbExp <= expectedRgb(refX, refY, drawRequests, objRgb);
            hSyncExp <= !(refX >= invadersPkg::hSyncStart && refX < invadersPkg::hSyncEnd);
            vSyncExp <= !(refY >= invadersPkg::vSyncStart && refY < invadersPkg::vSyncEnd);
            colExp <= frameStart ? hitsNow : (hitsNow & ~seenRef);
            seenRef <= frameStart ? hitsNow : (seenRef | hitsNow);
            scoreRef <= addPoints(scoreRef, colExp);
        end
    end

    frameCheck: assert property (@(posedge clk) disable iff (!rstN)
        int'(pixelX) == refX && int'(pixelY) == refY && startOfFrame == frameStart)
        else begin
            frameErrors++;
            $display("mismatch at %0t: pixelX,pixelY,startOfFrame ",
                "got %0d,%0d,%b expected %0d,%0d,%b",
                $time, $sampled(pixelX), $sampled(pixelY), $sampled(startOfFrame),
                $sampled(refX), $sampled(refY), $sampled(frameStart));
        end

    mixCheck: assert property (@(posedge clk) disable iff (!rstN) vgaRgb == rgbExp)
        else begin
            mixErrors++;
            $display("mismatch at %0t: vgaRgb got %h expected %h",
                $time, $sampled(vgaRgb), $sampled(rgbExp));
        end

    syncCheck: assert property (@(posedge clk) disable iff (!rstN)
        vgaHSync == hSyncExp && vgaVSync == vSyncExp)
        else begin
            syncErrors++;
            $display("mismatch at %0t: vgaHSync,vgaVSync got %b,%b expected %b,%b",
                $time, $sampled(vgaHSync), $sampled(vgaVSync), $sampled(hSyncExp),
                $sampled(vSyncExp));
        end

    hitCheck: assert property (@(posedge clk) disable iff (!rstN) collision == colExp)
        else begin
            hitErrors++;
            $display("mismatch at %0t: collision got %b expected %b",
                $time, $sampled(collision), $sampled(colExp));
        end

    scoreCheck: assert property (@(posedge clk) disable iff (!rstN)
        {hex2, hex1, hex0} == {segOf(scoreRef / 100), segOf((scoreRef / 10) % 10),
                               segOf(scoreRef % 10)})
        else begin
            scoreErrors++;
            $display("mismatch at %0t: hex2,hex1,hex0 got %h,%h,%h expected score %0d",
                $time, $sampled(hex2), $sampled(hex1), $sampled(hex0), $sampled(scoreRef));
        end

    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic checkCtrl(input logic [3:0] en, input logic [3:0] rst,
            input invadersPkg::stageT stage, input logic won, input logic over);
        logic [12:0] got;
        logic [12:0] want;
        got = {enablePlayer, enableMonsters, enableAsteroids, enableBoss, playerRstN,
               monstersRstN, asteroidsRstN, bossRstN, stageNum, gameWon, gameOver};
        want = {en, rst, stage, won, over};
        assert (got == want) else begin
            ctrlErrors++;
            $display("mismatch at %0t: enables,resets,stageNum,won,over got %b expected %b",
                $time, got, want);
        end
    endtask

    task automatic runGameSequence();
        startGame = 1'b1;
        waitCycles(1);
        startGame = 1'b0;
        checkCtrl(4'b0000, 4'b0000, 3'd0, 1'b0, 1'b0);   // stage load
        waitCycles(1);
        checkCtrl(4'b1100, 4'b1111, 3'd0, 1'b0, 1'b0);
        winStage = 1'b1;
        waitCycles(1);
        winStage = 1'b0;
        checkCtrl(4'b0000, 4'b0000, 3'd1, 1'b0, 1'b0);
        waitCycles(1);
        checkCtrl(4'b1100, 4'b1111, 3'd1, 1'b0, 1'b0);
        cheatN = 1'b0;                                    // skip to the asteroids
        waitCycles(1);
        cheatN = 1'b1;
        checkCtrl(4'b0000, 4'b0000, 3'd2, 1'b0, 1'b0);
        waitCycles(1);
        checkCtrl(4'b1010, 4'b1111, 3'd2, 1'b0, 1'b0);
        pause = 1'b1;
        waitCycles(1);
        checkCtrl(4'b0000, 4'b1111, 3'd2, 1'b0, 1'b0);
        waitCycles(4);
        checkCtrl(4'b0000, 4'b1111, 3'd2, 1'b0, 1'b0);
        pause = 1'b0;
        waitCycles(1);
        checkCtrl(4'b1010, 4'b1111, 3'd2, 1'b0, 1'b0);
        winStage = 1'b1;
        waitCycles(1);
        winStage = 1'b0;
        checkCtrl(4'b0000, 4'b0000, 3'd3, 1'b0, 1'b0);
        waitCycles(1);
        checkCtrl(4'b1001, 4'b1111, 3'd3, 1'b0, 1'b0);
        winStage = 1'b1;                                  // boss beaten
        waitCycles(1);
        winStage = 1'b0;
        checkCtrl(4'b0000, 4'b1111, 3'd3, 1'b1, 1'b0);
        startGame = 1'b1;
        waitCycles(1);
        startGame = 1'b0;
        checkCtrl(4'b0000, 4'b0000, 3'd0, 1'b0, 1'b0);
        waitCycles(1);
        checkCtrl(4'b1100, 4'b1111, 3'd0, 1'b0, 1'b0);
        playerDead = 1'b1;
        waitCycles(1);
        playerDead = 1'b0;
        checkCtrl(4'b0000, 4'b1111, 3'd0, 1'b0, 1'b1);
        startGame = 1'b1;
        waitCycles(1);
        startGame = 1'b0;
        checkCtrl(4'b0000, 4'b0000, 3'd0, 1'b0, 1'b0);
        waitCycles(1);
        checkCtrl(4'b1100, 4'b1111, 3'd0, 1'b0, 1'b0);
    endtask

    initial begin
        void'($urandom(32'h6f3b));
        rstN = 1'b0;
        startGame = 1'b0;
        cheatN = 1'b1;
        pause = 1'b0;
        winStage = 1'b0;
        playerDead = 1'b0;
        drawRequests = '0;
        objRgb = '0;
        repeat (3) @(posedge clk);
        #1 rstN = 1'b1;
        fork
            repeat (5 * invadersPkg::hTotal * invadersPkg::vTotal) begin
                @(posedge clk);
                #1;
                drawRequests = 9'($urandom & $urandom);  // roughly a quarter of the objects
                for (int i = 0; i < invadersPkg::numObjects; i++) begin
                    objRgb[i] = 8'($urandom);
                end
            end
            runGameSequence();
        join
        $display("errors: frame %0d, mixer %0d, sync %0d, collision %0d, score %0d, control %0d",
            frameErrors, mixErrors, syncErrors, hitErrors, scoreErrors, ctrlErrors);
        if (frameErrors + mixErrors + syncErrors + hitErrors + scoreErrors + ctrlErrors == 0)
        begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // six frames plus margin
    initial begin
        #((6 * invadersPkg::hTotal * invadersPkg::vTotal + 200) * 10);
        $display("timeout: simulation did not reach the end of the tests");
        $display("Test failures found");
        $finish;
    end

endmodule

/* invadersCore.f */
source/invadersPkg.sv
source/rasterScanner.sv
source/objectMixer.sv
source/hitDetection.sv
source/gameController.sv
source/scoreCounter.sv
source/invadersCore.sv
dv/invadersCoreTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= invadersCoreTb
FILELIST ?= invadersCore.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o sim
	@out=$$(./$(BUILD_DIR)/sim); echo "$$out"; echo "$$out" | grep -qx "All tests passed!"

clean:
	rm -rf $(BUILD_DIR)
